//--- rtl/ip_hdr_pkg.sv
//******************************
// ip header definitions
// field widths and the packed header
// struct carried through the mux
//******************************
`default_nettype none

package ip_hdr_pkg;

    // field widths
    localparam int LENGTH_W = 16;
    localparam int TTL_W    = 8;
    localparam int PROTO_W  = 8;
    localparam int ADDR_W   = 32;

    // header fields kept by the mux, 96 bits in all
    typedef struct packed {
        logic [LENGTH_W-1:0] length;
        logic [TTL_W-1:0]    ttl;
        logic [PROTO_W-1:0]  protocol;
        logic [ADDR_W-1:0]   source_ip;
        logic [ADDR_W-1:0]   dest_ip;
    } ip_hdr_t;

endpackage

`default_nettype wire

//--- rtl/stream_pkg.sv
//******************************
// payload stream definitions
// data width default, input count
// and select width
//******************************
`default_nettype none

package stream_pkg;

    // payload data width, keep is one bit per byte
    localparam int DATA_W_DEFAULT = 64;

    // number of frame inputs on the mux
    localparam int NUM_INPUTS = 2;

    // width of the select value
    localparam int SEL_W = 1;

endpackage

`default_nettype wire

//--- rtl/ip_payload_if.sv
//******************************
// payload beat link
// one beat from the frame select
// FSM into the output skid buffer
//******************************
`timescale 1ns/1ns
`default_nettype none

interface ip_payload_if #(
    parameter int DATA_W = stream_pkg::DATA_W_DEFAULT
);

    logic [DATA_W-1:0]   tdata;
    logic [DATA_W/8-1:0] tkeep;
    // beat accepted from the selected input this cycle
    logic                tvalid;
    logic                tlast;
    logic                tuser;
    // skid buffer can take a beat next cycle
    logic                ready_early;

    modport src (
        output tdata, tkeep, tvalid, tlast, tuser,
        input  ready_early
    );

    modport snk (
        input  tdata, tkeep, tvalid, tlast, tuser,
        output ready_early
    );

endinterface

`default_nettype wire

//--- rtl/frame_select_fsm.sv
//******************************
// frame select FSM
// latches the select value at frame
// start, drives the header ready pulse
// and input tready, and muxes the
// latched input's payload beats
//******************************
`timescale 1ns/1ns
`default_nettype none

module frame_select_fsm #(
    parameter int DATA_W = 64
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       enable,
    input  logic [stream_pkg::SEL_W-1:0]               select,
    input  logic [stream_pkg::NUM_INPUTS-1:0]          in_hdr_valid,
    output logic [stream_pkg::NUM_INPUTS-1:0]          in_hdr_ready,
    input  logic                                       out_hdr_valid,
    output logic                                       hdr_load,
    output logic [stream_pkg::SEL_W-1:0]               load_sel,
    input  logic [stream_pkg::NUM_INPUTS-1:0][DATA_W-1:0]   in_tdata,
    input  logic [stream_pkg::NUM_INPUTS-1:0][DATA_W/8-1:0] in_tkeep,
    input  logic [stream_pkg::NUM_INPUTS-1:0]          in_tvalid,
    input  logic [stream_pkg::NUM_INPUTS-1:0]          in_tlast,
    input  logic [stream_pkg::NUM_INPUTS-1:0]          in_tuser,
    output logic [stream_pkg::NUM_INPUTS-1:0]          in_tready,
    ip_payload_if.src                                  beat
);

    logic                            frame_q, frame_d;
    logic [stream_pkg::SEL_W-1:0]    sel_q, sel_d;
    logic [stream_pkg::NUM_INPUTS-1:0] hdr_ready_q, hdr_ready_d;
    logic [stream_pkg::NUM_INPUTS-1:0] tready_q, tready_d;
    logic                            start;
    logic                            accept;

    assign in_hdr_ready = hdr_ready_q;
    assign in_tready    = tready_q;

    // frame start looks at the live select, not the latched one
    assign start    = ~frame_q & enable & in_hdr_valid[select] & ~out_hdr_valid;
    assign hdr_load = start;
    assign load_sel = select;

    // beat transfer on the latched input
    assign accept = frame_q & in_tvalid[sel_q] & tready_q[sel_q];

    always_comb begin
        frame_d     = frame_q;
        sel_d       = sel_q;
        // ready pulse drops once the source sees it
        hdr_ready_d = hdr_ready_q & ~in_hdr_valid;

        if (frame_q) begin
            if (accept) begin
                frame_d = ~in_tlast[sel_q];
            end
        end else if (start) begin
            frame_d            = 1'b1;
            sel_d              = select;
            hdr_ready_d[select] = 1'b1;
        end

        // only the latched port gets tready, and only inside a frame
        tready_d        = '0;
        tready_d[sel_d] = beat.ready_early & frame_d;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame_q     <= 1'b0;
            sel_q       <= '0;
            hdr_ready_q <= '0;
            tready_q    <= '0;
        end else begin
            frame_q     <= frame_d;
            sel_q       <= sel_d;
            hdr_ready_q <= hdr_ready_d;
            tready_q    <= tready_d;
        end
    end

    // payload of the latched input
    assign beat.tdata  = in_tdata[sel_q];
    assign beat.tkeep  = in_tkeep[sel_q];
    assign beat.tvalid = accept;
    assign beat.tlast  = in_tlast[sel_q];
    assign beat.tuser  = in_tuser[sel_q];

endmodule

`default_nettype wire

//--- rtl/hdr_capture.sv
//******************************
// header capture register
// picks the header of the starting
// input and holds it with a valid
// flag until the sink takes it
//******************************
`timescale 1ns/1ns
`default_nettype none

module hdr_capture (
    input  logic                                             clk,
    input  logic                                             rst,
    input  ip_hdr_pkg::ip_hdr_t [stream_pkg::NUM_INPUTS-1:0] in_hdr,
    input  logic                                             hdr_load,
    input  logic [stream_pkg::SEL_W-1:0]                     load_sel,
    output ip_hdr_pkg::ip_hdr_t                              out_hdr,
    output logic                                             out_hdr_valid,
    input  logic                                             out_hdr_ready
);

    ip_hdr_pkg::ip_hdr_t hdr_q;
    logic                valid_q;

    assign out_hdr       = hdr_q;
    assign out_hdr_valid = valid_q;

    // load only comes while valid is low, so no overlap with a pending header
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (hdr_load) begin
            valid_q <= 1'b1;
        end else if (out_hdr_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_load) begin
            hdr_q <= in_hdr[load_sel];
        end
    end

endmodule

`default_nettype wire

//--- rtl/payload_skid.sv
//******************************
// payload skid buffer
// output register plus one temp
// register so the source can see
// back-pressure a cycle late
//******************************
`timescale 1ns/1ns
`default_nettype none

module payload_skid #(
    parameter int DATA_W = 64
) (
    input  logic                clk,
    input  logic                rst,
    ip_payload_if.snk           beat,
    output logic [DATA_W-1:0]   out_tdata,
    output logic [DATA_W/8-1:0] out_tkeep,
    output logic                out_tvalid,
    output logic                out_tlast,
    output logic                out_tuser,
    input  logic                out_tready
);

    localparam int KEEP_W = DATA_W / 8;

    logic [DATA_W-1:0] out_data_q, tmp_data_q;
    logic [KEEP_W-1:0] out_keep_q, tmp_keep_q;
    logic              out_last_q, tmp_last_q;
    logic              out_user_q, tmp_user_q;
    logic              out_valid_q, tmp_valid_q;
    // registered copy of ready_early, matches the source's tready
    logic              ready_q;

    logic              in_to_out;
    logic              in_to_tmp;
    logic              tmp_to_out;

    // room next cycle: sink drains, both empty, or temp empty and no beat arriving
    assign beat.ready_early = out_tready | (~tmp_valid_q & ~out_valid_q) |
                              (~tmp_valid_q & ~beat.tvalid);

    assign in_to_out  = ready_q & (out_tready | ~out_valid_q);
    assign in_to_tmp  = ready_q & ~(out_tready | ~out_valid_q);
    assign tmp_to_out = ~ready_q & out_tready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_q     <= 1'b0;
            out_valid_q <= 1'b0;
            tmp_valid_q <= 1'b0;
        end else begin
            ready_q <= beat.ready_early;
            if (in_to_out) begin
                out_valid_q <= beat.tvalid;
            end else if (in_to_tmp) begin
                tmp_valid_q <= beat.tvalid;
            end else if (tmp_to_out) begin
                out_valid_q <= tmp_valid_q;
                tmp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            out_data_q <= beat.tdata;
            out_keep_q <= beat.tkeep;
            out_last_q <= beat.tlast;
            out_user_q <= beat.tuser;
        end else if (tmp_to_out) begin
            out_data_q <= tmp_data_q;
            out_keep_q <= tmp_keep_q;
            out_last_q <= tmp_last_q;
            out_user_q <= tmp_user_q;
        end
        if (in_to_tmp) begin
            tmp_data_q <= beat.tdata;
            tmp_keep_q <= beat.tkeep;
            tmp_last_q <= beat.tlast;
            tmp_user_q <= beat.tuser;
        end
    end

    assign out_tdata  = out_data_q;
    assign out_tkeep  = out_keep_q;
    assign out_tvalid = out_valid_q;
    assign out_tlast  = out_last_q;
    assign out_tuser  = out_user_q;

endmodule

`default_nettype wire

//--- rtl/ip_mux_2.sv
//******************************
// two input IP frame mux
// picks one input per frame, passes
// its header and payload to the output
//******************************
`timescale 1ns/1ns
`default_nettype none

module ip_mux_2 #(
    parameter int DATA_W = stream_pkg::DATA_W_DEFAULT
) (
    input  logic                            clk,
    input  logic                            rst,

    // input 0
    input  logic                            input_0_ip_hdr_valid,
    output logic                            input_0_ip_hdr_ready,
    input  logic [ip_hdr_pkg::LENGTH_W-1:0] input_0_ip_length,
    input  logic [ip_hdr_pkg::TTL_W-1:0]    input_0_ip_ttl,
    input  logic [ip_hdr_pkg::PROTO_W-1:0]  input_0_ip_protocol,
    input  logic [ip_hdr_pkg::ADDR_W-1:0]   input_0_ip_source_ip,
    input  logic [ip_hdr_pkg::ADDR_W-1:0]   input_0_ip_dest_ip,
    input  logic [DATA_W-1:0]               input_0_ip_payload_tdata,
    input  logic [DATA_W/8-1:0]             input_0_ip_payload_tkeep,
    input  logic                            input_0_ip_payload_tvalid,
    output logic                            input_0_ip_payload_tready,
    input  logic                            input_0_ip_payload_tlast,
    input  logic                            input_0_ip_payload_tuser,

    // input 1
    input  logic                            input_1_ip_hdr_valid,
    output logic                            input_1_ip_hdr_ready,
    input  logic [ip_hdr_pkg::LENGTH_W-1:0] input_1_ip_length,
    input  logic [ip_hdr_pkg::TTL_W-1:0]    input_1_ip_ttl,
    input  logic [ip_hdr_pkg::PROTO_W-1:0]  input_1_ip_protocol,
    input  logic [ip_hdr_pkg::ADDR_W-1:0]   input_1_ip_source_ip,
    input  logic [ip_hdr_pkg::ADDR_W-1:0]   input_1_ip_dest_ip,
    input  logic [DATA_W-1:0]               input_1_ip_payload_tdata,
    input  logic [DATA_W/8-1:0]             input_1_ip_payload_tkeep,
    input  logic                            input_1_ip_payload_tvalid,
    output logic                            input_1_ip_payload_tready,
    input  logic                            input_1_ip_payload_tlast,
    input  logic                            input_1_ip_payload_tuser,

    // output
    output logic                            output_ip_hdr_valid,
    input  logic                            output_ip_hdr_ready,
    output logic [ip_hdr_pkg::LENGTH_W-1:0] output_ip_length,
    output logic [ip_hdr_pkg::TTL_W-1:0]    output_ip_ttl,
    output logic [ip_hdr_pkg::PROTO_W-1:0]  output_ip_protocol,
    output logic [ip_hdr_pkg::ADDR_W-1:0]   output_ip_source_ip,
    output logic [ip_hdr_pkg::ADDR_W-1:0]   output_ip_dest_ip,
    output logic [DATA_W-1:0]               output_ip_payload_tdata,
    output logic [DATA_W/8-1:0]             output_ip_payload_tkeep,
    output logic                            output_ip_payload_tvalid,
    input  logic                            output_ip_payload_tready,
    output logic                            output_ip_payload_tlast,
    output logic                            output_ip_payload_tuser,

    // control
    input  logic                            enable,
    input  logic [stream_pkg::SEL_W-1:0]    select
);

    localparam int N = stream_pkg::NUM_INPUTS;

    ip_hdr_pkg::ip_hdr_t [N-1:0] in_hdr;
    ip_hdr_pkg::ip_hdr_t         out_hdr;
    logic [N-1:0]                in_hdr_valid;
    logic [N-1:0]                in_hdr_ready;
    logic                        hdr_load;
    logic [stream_pkg::SEL_W-1:0] load_sel;
    logic [N-1:0][DATA_W-1:0]    in_tdata;
    logic [N-1:0][DATA_W/8-1:0]  in_tkeep;
    logic [N-1:0]                in_tvalid;
    logic [N-1:0]                in_tready;
    logic [N-1:0]                in_tlast;
    logic [N-1:0]                in_tuser;

    ip_payload_if #(.DATA_W(DATA_W)) beat_if ();

    // pack the per-input ports
    assign in_hdr[0] = '{length: input_0_ip_length, ttl: input_0_ip_ttl,
                         protocol: input_0_ip_protocol, source_ip: input_0_ip_source_ip,
                         dest_ip: input_0_ip_dest_ip};
    assign in_hdr[1] = '{length: input_1_ip_length, ttl: input_1_ip_ttl,
                         protocol: input_1_ip_protocol, source_ip: input_1_ip_source_ip,
                         dest_ip: input_1_ip_dest_ip};
    assign in_hdr_valid = {input_1_ip_hdr_valid, input_0_ip_hdr_valid};
    assign in_tdata     = {input_1_ip_payload_tdata, input_0_ip_payload_tdata};
    assign in_tkeep     = {input_1_ip_payload_tkeep, input_0_ip_payload_tkeep};
    assign in_tvalid    = {input_1_ip_payload_tvalid, input_0_ip_payload_tvalid};
    assign in_tlast     = {input_1_ip_payload_tlast, input_0_ip_payload_tlast};
    assign in_tuser     = {input_1_ip_payload_tuser, input_0_ip_payload_tuser};

    assign input_0_ip_hdr_ready      = in_hdr_ready[0];
    assign input_1_ip_hdr_ready      = in_hdr_ready[1];
    assign input_0_ip_payload_tready = in_tready[0];
    assign input_1_ip_payload_tready = in_tready[1];

    // unpack the output header
    assign output_ip_length    = out_hdr.length;
    assign output_ip_ttl       = out_hdr.ttl;
    assign output_ip_protocol  = out_hdr.protocol;
    assign output_ip_source_ip = out_hdr.source_ip;
    assign output_ip_dest_ip   = out_hdr.dest_ip;

    frame_select_fsm #(.DATA_W(DATA_W)) u_fsm (
        .clk           (clk),
        .rst           (rst),
        .enable        (enable),
        .select        (select),
        .in_hdr_valid  (in_hdr_valid),
        .in_hdr_ready  (in_hdr_ready),
        .out_hdr_valid (output_ip_hdr_valid),
        .hdr_load      (hdr_load),
        .load_sel      (load_sel),
        .in_tdata      (in_tdata),
        .in_tkeep      (in_tkeep),
        .in_tvalid     (in_tvalid),
        .in_tlast      (in_tlast),
        .in_tuser      (in_tuser),
        .in_tready     (in_tready),
        .beat          (beat_if)
    );

    hdr_capture u_hdr (
        .clk           (clk),
        .rst           (rst),
        .in_hdr        (in_hdr),
        .hdr_load      (hdr_load),
        .load_sel      (load_sel),
        .out_hdr       (out_hdr),
        .out_hdr_valid (output_ip_hdr_valid),
        .out_hdr_ready (output_ip_hdr_ready)
    );

    payload_skid #(.DATA_W(DATA_W)) u_skid (
        .clk        (clk),
        .rst        (rst),
        .beat       (beat_if),
        .out_tdata  (output_ip_payload_tdata),
        .out_tkeep  (output_ip_payload_tkeep),
        .out_tvalid (output_ip_payload_tvalid),
        .out_tlast  (output_ip_payload_tlast),
        .out_tuser  (output_ip_payload_tuser),
        .out_tready (output_ip_payload_tready)
    );

endmodule

`default_nettype wire

//--- bench/ip_mux_2_tb.sv
//******************************
// testbench for the two input IP
// frame mux, reference queues for
// headers and beats, assertions on
// both outputs and on input ready
//******************************
`timescale 1ns/1ns
`default_nettype none

module ip_mux_2_tb;

    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
        logic        user;
    } beat_t;

    logic                clk;
    logic                rst;
    logic                enable;
    logic                select;
    logic [1:0]          in_hdr_valid;
    logic [1:0]          in_hdr_ready;
    ip_hdr_pkg::ip_hdr_t in_hdr [2];
    logic [63:0]         in_tdata [2];
    logic [7:0]          in_tkeep [2];
    logic [1:0]          in_tvalid;
    logic [1:0]          in_tready;
    logic [1:0]          in_tlast;
    logic [1:0]          in_tuser;
    logic                out_hdr_valid;
    logic                out_hdr_ready = 1'b0;
    ip_hdr_pkg::ip_hdr_t out_hdr;
    beat_t               out_beat;
    logic                out_tvalid;
    logic                out_tready = 1'b0;

    logic                bp_mode;
    logic                gate_window;
    logic                beat_fire = 1'b0;
    logic                hdr_fire = 1'b0;
    logic [1:0]          frame_open = 2'b00;
    string               test_name;
    integer              seed = 32'ha9ef3280;
    int                  cycles = 0;
    int                  hdrs_sent [2] = '{0, 0};
    int                  hdr_pulses [2] = '{0, 0};
    beat_t               beat_q [$];
    ip_hdr_pkg::ip_hdr_t hdr_q [$];
    beat_t               exp_beat;
    ip_hdr_pkg::ip_hdr_t exp_hdr;
    int                  beat_count = 0;
    int                  hdr_count = 0;

    ip_mux_2 #(.DATA_W(64)) dut (
        .clk                       (clk),
        .rst                       (rst),
        .input_0_ip_hdr_valid      (in_hdr_valid[0]),
        .input_0_ip_hdr_ready      (in_hdr_ready[0]),
        .input_0_ip_length         (in_hdr[0].length),
        .input_0_ip_ttl            (in_hdr[0].ttl),
        .input_0_ip_protocol       (in_hdr[0].protocol),
        .input_0_ip_source_ip      (in_hdr[0].source_ip),
        .input_0_ip_dest_ip        (in_hdr[0].dest_ip),
        .input_0_ip_payload_tdata  (in_tdata[0]),
        .input_0_ip_payload_tkeep  (in_tkeep[0]),
        .input_0_ip_payload_tvalid (in_tvalid[0]),
        .input_0_ip_payload_tready (in_tready[0]),
        .input_0_ip_payload_tlast  (in_tlast[0]),
        .input_0_ip_payload_tuser  (in_tuser[0]),
        .input_1_ip_hdr_valid      (in_hdr_valid[1]),
        .input_1_ip_hdr_ready      (in_hdr_ready[1]),
        .input_1_ip_length         (in_hdr[1].length),
        .input_1_ip_ttl            (in_hdr[1].ttl),
        .input_1_ip_protocol       (in_hdr[1].protocol),
        .input_1_ip_source_ip      (in_hdr[1].source_ip),
        .input_1_ip_dest_ip        (in_hdr[1].dest_ip),
        .input_1_ip_payload_tdata  (in_tdata[1]),
        .input_1_ip_payload_tkeep  (in_tkeep[1]),
        .input_1_ip_payload_tvalid (in_tvalid[1]),
        .input_1_ip_payload_tready (in_tready[1]),
        .input_1_ip_payload_tlast  (in_tlast[1]),
        .input_1_ip_payload_tuser  (in_tuser[1]),
        .output_ip_hdr_valid       (out_hdr_valid),
        .output_ip_hdr_ready       (out_hdr_ready),
        .output_ip_length          (out_hdr.length),
        .output_ip_ttl             (out_hdr.ttl),
        .output_ip_protocol        (out_hdr.protocol),
        .output_ip_source_ip       (out_hdr.source_ip),
        .output_ip_dest_ip         (out_hdr.dest_ip),
        .output_ip_payload_tdata   (out_beat.data),
        .output_ip_payload_tkeep   (out_beat.keep),
        .output_ip_payload_tvalid  (out_tvalid),
        .output_ip_payload_tready  (out_tready),
        .output_ip_payload_tlast   (out_beat.last),
        .output_ip_payload_tuser   (out_beat.user),
        .enable                    (enable),
        .select                    (select)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // new random header on one input, expected value queued first
    task automatic raise_header(input int port);
        logic [31:0] r;
        r = rand_word();
        in_hdr[port].length    = r[15:0];
        in_hdr[port].ttl       = r[23:16];
        in_hdr[port].protocol  = r[31:24];
        in_hdr[port].source_ip = rand_word();
        in_hdr[port].dest_ip   = rand_word();
        hdr_q.push_back(in_hdr[port]);
        hdrs_sent[port]++;
        in_hdr_valid[port] = 1'b1;
    endtask

    task automatic wait_header_taken(input int port);
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            seen = in_hdr_ready[port];
        end
        #1;
        in_hdr_valid[port] = 1'b0;
    endtask

    // one frame of random beats, optional idle gaps between them
    task automatic send_frame(input int port, input int beats, input logic gaps);
        logic [31:0] r;
        int          gap;
        logic        taken;
        for (int i = 0; i < beats; i++) begin
            r = rand_word();
            gap = gaps ? int'(r[1:0]) : 0;
            if (gap != 0) begin
                in_tvalid[port] = 1'b0;
            end
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            in_tdata[port]  = {rand_word(), rand_word()};
            in_tkeep[port]  = r[15:8];
            in_tuser[port]  = r[16];
            in_tlast[port]  = (i == beats - 1);
            in_tvalid[port] = 1'b1;
            taken = 1'b0;
            while (!taken) begin
                @(posedge clk);
                taken = in_tready[port];
            end
            beat_q.push_back({in_tdata[port], in_tkeep[port], in_tlast[port], in_tuser[port]});
            #1;
        end
        in_tvalid[port] = 1'b0;
        in_tlast[port]  = 1'b0;
    endtask

    // output side ready, random under back-pressure
    always @(posedge clk) begin
        logic [31:0] r;
        #1;
        r = rand_word();
        out_tready    = ~bp_mode | r[0];
        out_hdr_ready = ~bp_mode | r[1];
    end

    always @(posedge clk) begin
        beat_fire <= out_tvalid & out_tready;
        hdr_fire  <= out_hdr_valid & out_hdr_ready;
        cycles    <= cycles + 1;
        for (int p = 0; p < 2; p++) begin
            if (in_hdr_ready[p]) begin
                hdr_pulses[p] <= hdr_pulses[p] + 1;
            end
            if (in_tvalid[p] & in_tready[p] & in_tlast[p]) begin
                frame_open[p] <= 1'b0;
            end else if (in_hdr_valid[p] & in_hdr_ready[p]) begin
                frame_open[p] <= 1'b1;
            end
        end
        if (cycles == 4000) begin
            fail_run($sformatf("Timeout in %s after %0d cycles", test_name, cycles));
        end
    end

    // queue heads move half a cycle away from the sampling edge
    always @(negedge clk) begin
        if (beat_fire && beat_q.size() != 0) begin
            beat_q.delete(0);
        end
        if (hdr_fire && hdr_q.size() != 0) begin
            hdr_q.delete(0);
        end
        beat_count = beat_q.size();
        hdr_count  = hdr_q.size();
        exp_beat   = (beat_count != 0) ? beat_q[0] : '0;
        exp_hdr    = (hdr_count != 0) ? hdr_q[0] : '0;
    end

    assert property (@(posedge clk) disable iff (rst) out_tvalid |-> beat_count != 0)
        else fail_run($sformatf("Output beat in %s with no beat pending", test_name));
    assert property (@(posedge clk) disable iff (rst) out_tvalid |-> out_beat == exp_beat)
        else fail_run($sformatf("Mismatch in %s: expected beat %h, actual %h",
                                test_name, exp_beat, out_beat));
    assert property (@(posedge clk) disable iff (rst) out_hdr_valid |-> hdr_count != 0)
        else fail_run($sformatf("Output header in %s with no header pending", test_name));
    assert property (@(posedge clk) disable iff (rst) out_hdr_valid |-> out_hdr == exp_hdr)
        else fail_run($sformatf("Mismatch in %s: expected header %h, actual %h",
                                test_name, exp_hdr, out_hdr));
    // a second cycle of hdr_ready would meet a dropped hdr_valid
    assert property (@(posedge clk) disable iff (rst) (in_hdr_ready & ~in_hdr_valid) == 2'b00)
        else fail_run($sformatf("Header ready in %s without a pending header", test_name));
    assert property (@(posedge clk) disable iff (rst)
                     (in_tready & ~(frame_open | in_hdr_ready)) == 2'b00)
        else fail_run($sformatf("Payload ready in %s on an input outside its frame", test_name));
    assert property (@(posedge clk) disable iff (rst)
                     gate_window |-> !out_hdr_valid && in_hdr_ready == 2'b00)
        else fail_run("A frame started while enable was low");

    initial begin
        rst          = 1'b1;
        enable       = 1'b0;
        select       = 1'b0;
        in_hdr_valid = 2'b00;
        in_tvalid    = 2'b00;
        in_tlast     = 2'b00;
        in_tuser     = 2'b00;
        bp_mode      = 1'b0;
        gate_window  = 1'b0;
        test_name    = "after_reset";
        for (int p = 0; p < 2; p++) begin
            in_hdr[p]   = '0;
            in_tdata[p] = '0;
            in_tkeep[p] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        assert ({out_hdr_valid, out_tvalid, in_hdr_ready, in_tready} == 6'b0)
            else fail_run($sformatf("Mismatch in %s: expected %b, actual %b", test_name, 6'b0,
                                    {out_hdr_valid, out_tvalid, in_hdr_ready, in_tready}));
        #1;
        enable    = 1'b1;
        test_name = "pass_through";
        raise_header(0);
        fork
            wait_header_taken(0);
            send_frame(0, 6, 1'b0);
        join

        bp_mode   = 1'b1;
        test_name = "back_pressure";
        for (int n = 0; n < 4; n++) begin
            select = n[0];
            raise_header(n % 2);
            fork
                wait_header_taken(n % 2);
                send_frame(n % 2, 12, 1'b1);
            join
        end

        // select moves to input 1 while input 0 is mid-frame
        bp_mode   = 1'b0;
        test_name = "select_hold";
        select    = 1'b0;
        raise_header(0);
        fork
            wait_header_taken(0);
            send_frame(0, 10, 1'b0);
            begin
                repeat (4) @(posedge clk);
                #1;
                select = 1'b1;
                raise_header(1);
                fork
                    wait_header_taken(1);
                    send_frame(1, 5, 1'b0);
                join
            end
        join

        test_name   = "enable_gate";
        enable      = 1'b0;
        gate_window = 1'b1;
        raise_header(1);
        repeat (20) @(posedge clk);
        #1;
        gate_window = 1'b0;
        enable      = 1'b1;
        fork
            wait_header_taken(1);
            send_frame(1, 4, 1'b1);
        join

        test_name = "drain";
        while (beat_q.size() != 0 || hdr_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (hdr_pulses[0] == hdrs_sent[0] && hdr_pulses[1] == hdrs_sent[1]) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            fail_run($sformatf("Mismatch in %s: expected hdr_ready pulses %0d/%0d, actual %0d/%0d",
                               test_name, hdrs_sent[0], hdrs_sent[1],
                               hdr_pulses[0], hdr_pulses[1]));
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
rtl/ip_hdr_pkg.sv
rtl/stream_pkg.sv
rtl/ip_payload_if.sv
rtl/frame_select_fsm.sv
rtl/hdr_capture.sv
rtl/payload_skid.sv
rtl/ip_mux_2.sv
bench/ip_mux_2_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with the DUT, then run it; a failing run exits non-zero
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module ip_mux_2_tb -f verilog.f -o ip_mux_2_tb_sim \
    && ./obj_dir/ip_mux_2_tb_sim \
    || exit 1
